//--- src.f
source/mmio_csr_pkg.sv
source/mmio_req_if.sv
source/mmio_stall_front.sv
source/mmio_write_capture.sv
source/mmio_read_path.sv
source/mmio_csr_top.sv
test/tb_clock_gen.sv
test/mmio_csr_sva.sv
test/mmio_csr_tb.sv

//--- Makefile
TOP = mmio_csr_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- test/mmio_csr_tb.sv
/* Directed testbench for the MMIO register target. Drives Avalon-style reads
   and writes through the stall ring and checks readback against a model. */

`timescale 1ns/1ps

module mmio_csr_tb;

    // About 43 commands at up to 17 cycles each plus reset and margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                                clk;
    logic                                reset_n;
    logic [mmio_csr_pkg::ADDR_WIDTH-1:0] address;
    logic [mmio_csr_pkg::DATA_BYTES-1:0] byteenable;
    mmio_csr_pkg::mmio_data_t            writedata;
    logic                                read;
    logic                                write;
    logic                                waitrequest;
    mmio_csr_pkg::mmio_data_t            readdata;
    logic                                readdatavalid;

    // Reference copy of the last captured write
    mmio_csr_pkg::mmio_data_t model_data;
    logic [63:0]              model_mask;
    logic [15:0]              model_addr;
    logic [5:0]               model_lane;

    integer seed = 32'h531c;
    // Free-running cycle count and accepted-command bookkeeping
    int cycle_count = 0;
    int accept_count = 0;
    int last_accept = 0;

    tb_clock_gen tb_clock_gen_inst (
        .clk     (clk),
        .reset_n (reset_n)
    );

    mmio_csr_top mmio_csr_top_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .address       (address),
        .byteenable    (byteenable),
        .writedata     (writedata),
        .read          (read),
        .write         (write),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

    task automatic abort_run(input string why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    // ========================================================================
    // Timeout and throttle monitor
    // ========================================================================

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            abort_run("Timeout: the run went past its cycle limit");
        end
        else if (reset_n && (read || write) && !waitrequest)
        begin
            // One slot per 16 cycles at most
            if (accept_count > 0 && (cycle_count - last_accept) < 16)
            begin
                abort_run("Two commands were accepted less than 16 cycles apart");
            end
            else
            begin
                last_accept <= cycle_count;
                accept_count <= accept_count + 1;
            end
        end
    end

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic check_data(input string name, input mmio_csr_pkg::mmio_data_t expected,
                              input mmio_csr_pkg::mmio_data_t actual);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            abort_run({"Mismatch on ", name});
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("Error at %0t ns: %s expected %0d actual %0d",
                     $time, name, expected, actual);
            abort_run({"Mismatch on ", name});
        end
    endtask

    // ========================================================================
    // Stimulus helpers and reference model
    // ========================================================================

    // Lowest enabled byte or 0 for an empty mask
    function automatic logic [5:0] lowest_enabled(input logic [63:0] mask);
        logic [5:0] lane;
        logic       found;
        lane = 6'd0;
        found = 1'b0;
        for (int i = 0; i < 64; i++)
        begin
            if (!found && mask[i])
            begin
                lane = 6'(i);
                found = 1'b1;
            end
        end
        return lane;
    endfunction

    function automatic mmio_csr_pkg::mmio_data_t random_word();
        mmio_csr_pkg::mmio_data_t word;
        for (int i = 0; i < 8; i++)
        begin
            word[i] = {$random(seed), $random(seed)};
        end
        return word;
    endfunction

    // Sparse mask with the low bytes cleared so the first lane lands anywhere
    function automatic logic [63:0] random_mask();
        logic [63:0] mask;
        int          shift;
        shift = $random(seed) & 63;
        mask = {$random(seed), $random(seed)} & {$random(seed), $random(seed)};
        mask = mask & ~((64'd1 << shift) - 64'd1);
        if (mask == '0)
        begin
            mask[shift] = 1'b1;
        end
        return mask;
    endfunction

    function automatic logic [15:0] csr_addr(input mmio_csr_pkg::csr_index_e idx);
        return 16'(idx);
    endfunction

    // Byte-merge into the model while mask, address and lane are replaced whole
    task automatic update_model(input logic [15:0] addr, input logic [63:0] be,
                                input mmio_csr_pkg::mmio_data_t data);
        logic [511:0] merged;
        logic [511:0] incoming;
        merged = model_data;
        incoming = data;
        for (int i = 0; i < 64; i++)
        begin
            if (be[i])
            begin
                merged[i*8 +: 8] = incoming[i*8 +: 8];
            end
        end
        model_data = merged;
        model_mask = be;
        model_addr = addr;
        model_lane = lowest_enabled(be);
    endtask

    function automatic mmio_csr_pkg::mmio_data_t expect_header(input logic [15:0] addr,
                                                               input logic [63:0] be);
        mmio_csr_pkg::mmio_data_t word;
        logic [31:0]              byte_addr;
        word = '0;
        // AFU feature type with the end-of-list bit
        word[0][63:60] = 4'h1;
        word[0][40] = 1'b1;
        word[1] = mmio_csr_pkg::ACCEL_ID[63:0];
        word[2] = mmio_csr_pkg::ACCEL_ID[127:64];
        byte_addr = {10'h0, addr, lowest_enabled(be)};
        word[7] = {byte_addr, byte_addr};
        return word;
    endfunction

    function automatic mmio_csr_pkg::mmio_data_t expect_status();
        mmio_csr_pkg::mmio_data_t word;
        word = '0;
        word[0] = {32'h0, mmio_csr_pkg::CLOCK_MHZ, 2'd3, 9'h0,
                   mmio_csr_pkg::WRITE512_OK, 4'h0};
        return word;
    endfunction

    // Address word plus either the lane's mask byte or the full mask
    function automatic mmio_csr_pkg::mmio_data_t expect_info(input logic full_mask);
        mmio_csr_pkg::mmio_data_t word;
        word = '0;
        word[0] = {42'h0, model_addr, model_lane};
        if (full_mask)
        begin
            word[1] = model_mask;
        end
        else
        begin
            word[1] = {56'h0, model_mask[{model_lane[5:3], 3'b000} +: 8]};
        end
        return word;
    endfunction

    function automatic mmio_csr_pkg::mmio_data_t expect_data64();
        mmio_csr_pkg::mmio_data_t word;
        word = '0;
        word[0] = model_data[model_lane[5:3]];
        return word;
    endfunction

    // ========================================================================
    // Bus tasks
    // ========================================================================

    // Returns on the edge where the command met waitrequest low
    task automatic wait_accept();
        do
        begin
            @(posedge clk);
        end
        while (waitrequest);
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [63:0] be,
                             input mmio_csr_pkg::mmio_data_t data);
        @(posedge clk);
        address <= addr;
        byteenable <= be;
        writedata <= data;
        write <= 1'b1;
        wait_accept();
        write <= 1'b0;
        // Park the fields on an unmapped index once the command is taken
        address <= '1;
        byteenable <= '0;
        update_model(addr, be, data);
    endtask

    task automatic bus_read(input logic [15:0] addr, input logic [63:0] be,
                            output mmio_csr_pkg::mmio_data_t data, output int edges);
        @(posedge clk);
        address <= addr;
        byteenable <= be;
        read <= 1'b1;
        wait_accept();
        read <= 1'b0;
        // Later bus values must not reach the response
        address <= '1;
        byteenable <= '0;
        // Edges from acceptance until valid is seen
        edges = 0;
        do
        begin
            @(posedge clk);
            edges++;
        end
        while (!readdatavalid);
        data = readdata;
    endtask

    task automatic read_check(input string name, input logic [15:0] addr,
                              input logic [63:0] be, input mmio_csr_pkg::mmio_data_t expected);
        mmio_csr_pkg::mmio_data_t data;
        int                       edges;
        bus_read(addr, be, data, edges);
        check_count({"readdatavalid latency on ", name}, 2, edges);
        check_data({"readdata on ", name}, expected, data);
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic test_reset_values();
        read_check("INFO512 after reset", csr_addr(mmio_csr_pkg::CSR_WR_INFO512), '1,
                   expect_info(1'b1));
        read_check("DATA512 after reset", csr_addr(mmio_csr_pkg::CSR_WR_DATA512), '1, '1);
    endtask

    task automatic test_header_status();
        logic [63:0] be;
        // First enabled byte at lane 24 with address bits set above the index
        be = {$random(seed), $random(seed)};
        be[23:0] = '0;
        be[24] = 1'b1;
        read_check("header lane 24", 16'h3000, be, expect_header(16'h3000, be));
        read_check("header lane 0", 16'h0000, '1, expect_header(16'h0000, '1));
        read_check("status", csr_addr(mmio_csr_pkg::CSR_STATUS), '1, expect_status());
    endtask

    task automatic test_full_write();
        mmio_csr_pkg::mmio_data_t data;
        mmio_csr_pkg::mmio_data_t info;
        logic [15:0]              addr;
        data = random_word();
        addr = 16'($random(seed));
        bus_write(addr, '1, data);
        // Full mask and lane 0 written out directly
        info = '0;
        info[0] = {42'h0, addr, 6'd0};
        info[1] = '1;
        read_check("DATA512 full write", csr_addr(mmio_csr_pkg::CSR_WR_DATA512), '1, data);
        read_check("INFO512 full write", csr_addr(mmio_csr_pkg::CSR_WR_INFO512), '1, info);
    endtask

    task automatic test_partial_merge();
        for (int n = 0; n < 6; n++)
        begin
            bus_write(16'($random(seed)), random_mask(), random_word());
            read_check("DATA512 merge", csr_addr(mmio_csr_pkg::CSR_WR_DATA512), '1,
                       model_data);
            read_check("DATA64 merge", csr_addr(mmio_csr_pkg::CSR_WR_DATA64), '1,
                       expect_data64());
            read_check("INFO64 merge", csr_addr(mmio_csr_pkg::CSR_WR_INFO64), '1,
                       expect_info(1'b0));
            read_check("INFO512 merge", csr_addr(mmio_csr_pkg::CSR_WR_INFO512), '1,
                       expect_info(1'b1));
        end
    endtask

    task automatic test_unmapped();
        read_check("index 1", 16'h0001, '1, '0);
        read_check("index 7", 16'h0007, '1, '0);
        read_check("index 12", 16'h000c, '1, '0);
        read_check("index 0xfff", 16'h0fff, '1, '0);
        // Index 3 with upper address bits set
        read_check("index 0x2003", 16'h2003, '1, '0);
    endtask

    initial
    begin
        address = '0;
        byteenable = '0;
        writedata = '0;
        read = 1'b0;
        write = 1'b0;
        model_data = '1;
        model_mask = '1;
        model_addr = '1;
        model_lane = '1;
        while (reset_n !== 1'b1)
        begin
            @(posedge clk);
        end

        test_reset_values();
        test_header_status();
        test_full_write();
        test_partial_merge();
        test_unmapped();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- test/mmio_csr_sva.sv
/* Handshake and read-latency assertions for the MMIO register target.
   Bound to mmio_csr_top at the bottom of this file. */

`timescale 1ns/1ps

module mmio_csr_sva (
    input logic clk,
    input logic reset_n,
    input logic read,
    input logic write,
    input logic waitrequest,
    input logic readdatavalid
);

    // Host never issues both commands at once
    assert property (@(posedge clk) disable iff (!reset_n) !(read && write))
        else $error("read and write asserted together");

    // The ring holds a single zero, so a low slot never repeats back to back
    assert property (@(posedge clk) disable iff (!reset_n) !waitrequest |=> waitrequest)
        else $error("waitrequest low for two cycles in a row");

    // Accepted read returns data two edges later
    assert property (@(posedge clk) disable iff (!reset_n)
        (read && !waitrequest) |-> ##2 readdatavalid)
        else $error("readdatavalid missing two edges after an accepted read");

    // No spurious valid pulses
    assert property (@(posedge clk) disable iff (!reset_n)
        readdatavalid |-> $past(read && !waitrequest, 2))
        else $error("readdatavalid without an accepted read two edges earlier");

    // Held low once reset has been seen for a full edge
    assert property (@(posedge clk) (!reset_n && $past(!reset_n)) |-> !readdatavalid)
        else $error("readdatavalid high during reset");

endmodule

bind mmio_csr_top mmio_csr_sva mmio_csr_sva_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .read          (read),
    .write         (write),
    .waitrequest   (waitrequest),
    .readdatavalid (readdatavalid)
);

//--- test/tb_clock_gen.sv
/* Testbench clock and reset source. 100 ns clock period, reset_n held
   low for the first 16 rising edges and released on an edge. */

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    // Half period of 50 ns
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Synchronous release after 16 edges
    initial
    begin
        reset_n = 1'b0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

//--- source/mmio_csr_top.sv
/* Top level of the MMIO register test target with plain Avalon-style ports.
   Connects the stall front end, write capture and read path. */

`timescale 1ns/1ps

module mmio_csr_top (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic [mmio_csr_pkg::ADDR_WIDTH-1:0] address,
    input  logic [mmio_csr_pkg::DATA_BYTES-1:0] byteenable,
    input  mmio_csr_pkg::mmio_data_t            writedata,
    input  logic                                read,
    input  logic                                write,
    output logic                                waitrequest,
    output mmio_csr_pkg::mmio_data_t            readdata,
    output logic                                readdatavalid
);

    // Accepted command bus
    mmio_req_if req_if ();

    // Captured write state toward the read path
    mmio_csr_pkg::mmio_data_t               wr_data;
    logic [mmio_csr_pkg::DATA_BYTES-1:0]    wr_mask;
    logic [mmio_csr_pkg::ADDR_WIDTH-1:0]    wr_addr;
    logic [5:0]                             wr_lane;

    mmio_stall_front mmio_stall_front_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .read        (read),
        .write       (write),
        .address     (address),
        .byteenable  (byteenable),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .req         (req_if.source)
    );

    mmio_write_capture mmio_write_capture_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (req_if.sink),
        .wr_data (wr_data),
        .wr_mask (wr_mask),
        .wr_addr (wr_addr),
        .wr_lane (wr_lane)
    );

    mmio_read_path mmio_read_path_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .req           (req_if.sink),
        .wr_data       (wr_data),
        .wr_mask       (wr_mask),
        .wr_addr       (wr_addr),
        .wr_lane       (wr_lane),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

endmodule

//--- source/mmio_read_path.sv
/* Two-stage read responder for the register map. Stage one latches the
   request and header word, stage two selects readdata by register index. */

`timescale 1ns/1ps

module mmio_read_path (
    input  logic                                clk,
    input  logic                                reset_n,
    mmio_req_if.sink                            req,
    input  mmio_csr_pkg::mmio_data_t            wr_data,
    input  logic [mmio_csr_pkg::DATA_BYTES-1:0] wr_mask,
    input  logic [mmio_csr_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  logic [5:0]                          wr_lane,
    output mmio_csr_pkg::mmio_data_t            readdata,
    output logic                                readdatavalid
);

    // ========================================================================
    // Stage one
    // ========================================================================

    logic                           read_req_q;
    mmio_csr_pkg::csr_index_e       read_idx_q;
    mmio_csr_pkg::mmio_data_t       header_q;
    logic [6:0]                     req_lane;
    // Byte address of the live request
    logic [31:0]                    req_byte_addr;

    assign req_lane      = mmio_csr_pkg::first_byte_lane(req.byteenable);
    assign req_byte_addr = 32'({req.address, req_lane[5:0]});

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            read_req_q <= 1'b0;
        end
        else
        begin
            read_req_q <= req.accepted && !req.is_write;
        end
    end

    // Index and header follow the bus every cycle
    always_ff @(posedge clk)
    begin
        read_idx_q <= mmio_csr_pkg::csr_index_e'(
            req.address[mmio_csr_pkg::CSR_INDEX_WIDTH-1:0]);

        header_q <= '0;
        // Single feature, type AFU, end of list
        header_q[0][63:60] <= mmio_csr_pkg::DFH_FEATURE_TYPE;
        header_q[0][mmio_csr_pkg::DFH_EOL_BIT] <= 1'b1;
        header_q[1] <= mmio_csr_pkg::ACCEL_ID[63:0];
        header_q[2] <= mmio_csr_pkg::ACCEL_ID[127:64];
        // Repeated so either 32-bit half can be read
        header_q[7] <= {req_byte_addr, req_byte_addr};
    end

    // ========================================================================
    // Stage two
    // ========================================================================

    logic [63:0]                status_word;
    // Address with its byte lane appended
    logic [63:0]                info_addr;
    mmio_csr_pkg::mmio_data_t   rd_next;

    assign status_word = {32'h0,
                          mmio_csr_pkg::CLOCK_MHZ,
                          mmio_csr_pkg::BUS_CODE_512,
                          9'h0,
                          mmio_csr_pkg::WRITE512_OK,
                          4'h0};

    assign info_addr = 64'({wr_addr, wr_lane});

    always_comb
    begin
        rd_next = '0;
        case (read_idx_q)
            mmio_csr_pkg::CSR_HEADER:     rd_next = header_q;
            mmio_csr_pkg::CSR_STATUS:     rd_next[0] = status_word;
            // Acts like a 64-bit port, lane picked by the first enabled byte
            mmio_csr_pkg::CSR_WR_DATA64:  rd_next[0] = wr_data[wr_lane[5:3]];
            mmio_csr_pkg::CSR_WR_INFO64:
            begin
                rd_next[0] = info_addr;
                rd_next[1] = 64'(wr_mask[{wr_lane[5:3], 3'b000} +: 8]);
            end
            mmio_csr_pkg::CSR_WR_DATA512: rd_next = wr_data;
            mmio_csr_pkg::CSR_WR_INFO512:
            begin
                rd_next[0] = info_addr;
                rd_next[1] = wr_mask;
            end
            default:                      rd_next = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            readdatavalid <= 1'b0;
        end
        else
        begin
            readdatavalid <= read_req_q;
        end
    end

    // Payload, qualified by readdatavalid
    always_ff @(posedge clk)
    begin
        readdata <= rd_next;
    end

endmodule

//--- source/mmio_write_capture.sv
/* Keeps the byte-merged data, mask, address and first byte lane of the
   last accepted write so the host can read them back. */

`timescale 1ns/1ps

module mmio_write_capture (
    input  logic                                clk,
    input  logic                                reset_n,
    mmio_req_if.sink                            req,
    output mmio_csr_pkg::mmio_data_t            wr_data,
    output logic [mmio_csr_pkg::DATA_BYTES-1:0] wr_mask,
    output logic [mmio_csr_pkg::ADDR_WIDTH-1:0] wr_addr,
    output logic [5:0]                          wr_lane
);

    // Flat views for byte slicing
    logic [mmio_csr_pkg::DATA_WIDTH-1:0] old_bits;
    logic [mmio_csr_pkg::DATA_WIDTH-1:0] new_bits;
    logic [mmio_csr_pkg::DATA_WIDTH-1:0] merged_bits;
    // Full function result, bit 6 flags an empty mask
    logic [6:0]                          lane_full;
    logic                                write_hit;

    assign old_bits  = wr_data;
    assign new_bits  = req.writedata;
    assign write_hit = req.accepted && req.is_write;
    assign lane_full = mmio_csr_pkg::first_byte_lane(req.byteenable);

    // Enabled bytes come from the host, the rest keep their old value
    always_comb
    begin
        merged_bits = old_bits;
        for (int i = 0; i < mmio_csr_pkg::DATA_BYTES; i++)
        begin
            if (req.byteenable[i])
            begin
                merged_bits[i*8 +: 8] = new_bits[i*8 +: 8];
            end
        end
    end

    // ========================================================================
    // Capture registers
    // ========================================================================

    // All ones after reset, so an untouched lane reads 63
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_data <= '1;
            wr_mask <= '1;
            wr_addr <= '1;
            wr_lane <= '1;
        end
        else if (write_hit)
        begin
            wr_data <= merged_bits;
            // Mask is stored whole, not merged
            wr_mask <= req.byteenable;
            wr_addr <= req.address;
            wr_lane <= lane_full[5:0];
        end
    end

endmodule

//--- source/mmio_stall_front.sv
/* Host-facing front end that throttles with a rotating waitrequest ring
   and hands accepted commands to the rest of the design. */

`timescale 1ns/1ps

module mmio_stall_front (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                read,
    input  logic                                write,
    input  logic [mmio_csr_pkg::ADDR_WIDTH-1:0] address,
    input  logic [mmio_csr_pkg::DATA_BYTES-1:0] byteenable,
    input  mmio_csr_pkg::mmio_data_t            writedata,
    output logic                                waitrequest,
    mmio_req_if.source                          req
);

    // ========================================================================
    // Stall ring
    // ========================================================================

    // A single zero circles the ring, so the host gets one slot in 16
    logic [15:0] stall_ring;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            stall_ring <= {{15{1'b1}}, 1'b0};
        end
        else
        begin
            stall_ring <= {stall_ring[14:0], stall_ring[15]};
        end
    end

    // Zero reaches bit 8 on the 8th edge after reset release
    assign waitrequest = stall_ring[8];

    // ========================================================================
    // Command acceptance
    // ========================================================================

    assign req.accepted   = (read || write) && !waitrequest;
    assign req.is_write   = write;
    // Fields are only meaningful while accepted is high
    assign req.address    = address;
    assign req.byteenable = byteenable;
    assign req.writedata  = writedata;

endmodule

//--- source/mmio_req_if.sv
/* One accepted host command, passed from the stall front end to the
   capture and read blocks. */

`timescale 1ns/1ps

interface mmio_req_if;

    // High only in the cycle where the command meets waitrequest low
    logic                                   accepted;
    // Write when set, read otherwise
    logic                                   is_write;
    logic [mmio_csr_pkg::ADDR_WIDTH-1:0]    address;
    logic [mmio_csr_pkg::DATA_BYTES-1:0]    byteenable;
    mmio_csr_pkg::mmio_data_t               writedata;

    // Front end side
    modport source (
        output accepted,
        output is_write,
        output address,
        output byteenable,
        output writedata
    );

    // Consumers, no back-pressure
    modport sink (
        input accepted,
        input is_write,
        input address,
        input byteenable,
        input writedata
    );

endinterface

//--- source/mmio_csr_pkg.sv
/* Shared widths, identity constants and register map for the MMIO test target.
   Every design and testbench file refers to these by scoped name. */

package mmio_csr_pkg;

    // ========================================================================
    // Bus geometry
    // ========================================================================

    // Word-index address, one step per 64-byte bus word
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_BYTES = 64;
    localparam int DATA_WIDTH = DATA_BYTES * 8;
    // Low address bits that select a register
    localparam int CSR_INDEX_WIDTH = 12;

    // ========================================================================
    // Identity and status constants
    // ========================================================================

    // Accelerator UUID, low half in header word 1, high half in word 2
    localparam logic [127:0] ACCEL_ID = 128'h3f8e_52c1_9d47_4b06_a2e9_71c5_0d3b_86f4;

    // Feature header fields
    localparam logic [3:0] DFH_FEATURE_TYPE = 4'h1;
    localparam int DFH_EOL_BIT = 40;

    // Reported clock, 100 ns period
    localparam logic [15:0] CLOCK_MHZ = 16'd10;
    // Bus code for a 512-bit read/write port
    localparam logic [1:0] BUS_CODE_512 = 2'h3;
    // A full 512-bit write is consumed
    localparam logic WRITE512_OK = 1'b1;

    // 512-bit word seen as eight 64-bit lanes
    typedef logic [7:0][63:0] mmio_data_t;

    // Register indices, anything else reads zero
    typedef enum logic [CSR_INDEX_WIDTH-1:0] {
        CSR_HEADER     = 12'd0,
        CSR_STATUS     = 12'd2,
        CSR_WR_DATA64  = 12'd4,
        CSR_WR_INFO64  = 12'd6,
        CSR_WR_DATA512 = 12'd8,
        CSR_WR_INFO512 = 12'd10
    } csr_index_e;

    // Position of the lowest set byte enable, DATA_BYTES when none is set
    function automatic logic [6:0] first_byte_lane(input logic [DATA_BYTES-1:0] mask);
        logic [6:0] lane;
        lane = 7'(DATA_BYTES);
        // Scan downward so the lowest set bit wins
        for (int i = DATA_BYTES - 1; i >= 0; i--)
        begin
            if (mask[i])
            begin
                lane = 7'(i);
            end
        end
        return lane;
    endfunction

endpackage
